// ==== list.f ====
cnn_pkg.sv
pe.sv
systolic_array.sv
conv_ctrl.sv
pooling_unit.sv
conv_top.sv
tb_conv_top.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary -Wno-fatal --top-module tb_conv_top -f list.f -o sim_conv > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_conv > sim.log 2>&1 ; cat sim.log
grep -q "TESTS PASSED" sim.log && echo "simulation ok" || { echo "simulation failed"; exit 1; }

// ==== tb_conv_top.sv ====
`timescale 1ns/1ps

module tb_conv_top;

  localparam int ROWS           = 4;
  localparam int COLS           = 4;
  localparam int FRAME_LEN      = 16;
  localparam int POOL_LEN       = 4;
  localparam int NF_W           = $clog2(COLS + 1);
  localparam int RESET_CYCLES   = 10;
  localparam int NUM_RUNS       = 4;
  localparam int TIMEOUT_CYCLES = NUM_RUNS * (ROWS + FRAME_LEN + ROWS + COLS + 20) + RESET_CYCLES;

  typedef cnn_pkg::weight_t wmat_t [ROWS][COLS];
  typedef cnn_pkg::data_t   frame_t [FRAME_LEN][ROWS];
  typedef cnn_pkg::psum_t   psum_list_t [$];

  logic                        clk;
  logic                        nrst;
  logic                        weight_load_i;
  cnn_pkg::weight_t [COLS-1:0] weight_i;
  logic                        start_i;
  cnn_pkg::data_t   [ROWS-1:0] act_i;
  logic [NF_W-1:0]             num_filter_i;
  logic [COLS-1:0]             pool_valid_o;
  cnn_pkg::psum_t   [COLS-1:0] pool_data_o;
  logic                        conv_finish_o;
  logic                        w_ps_o;

  integer         seed;
  int             cycle_cnt;
  int             finish_cnt;
  int             valid_cnt [COLS];
  cnn_pkg::psum_t exp_q [COLS][$];  // pooled results still owed per column
  wmat_t          w_rows;           // weights as they sit in the grid
  wmat_t          strobes;
  frame_t         frame;

  conv_top #(
    .ROWS      (ROWS),
    .COLS      (COLS),
    .FRAME_LEN (FRAME_LEN),
    .POOL_LEN  (POOL_LEN)
  ) dut_i (
    .clk           (clk),
    .nrst          (nrst),
    .weight_load_i (weight_load_i),
    .weight_i      (weight_i),
    .start_i       (start_i),
    .act_i         (act_i),
    .num_filter_i  (num_filter_i),
    .pool_valid_o  (pool_valid_o),
    .pool_data_o   (pool_data_o),
    .conv_finish_o (conv_finish_o),
    .w_ps_o        (w_ps_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
      abort_run($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
  endtask

  // max over each group of POOL_LEN dot products of one column
  function automatic psum_list_t pool_ref(input wmat_t w, input frame_t f, input int col);
    psum_list_t res;
    int         acc;
    int         best;
    for (int g = 0; g < FRAME_LEN / POOL_LEN; g++)
    begin
      best = 0;
      for (int k = 0; k < POOL_LEN; k++)
      begin
        acc = 0;
        for (int r = 0; r < ROWS; r++)
          acc += int'(w[r][col]) * int'(f[g*POOL_LEN+k][r]);
        if (k == 0 || acc > best)
          best = acc;
      end
      res.push_back(cnn_pkg::psum_t'(best));
    end
    return res;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic make_weights(input bit positive, output wmat_t s);
    for (int k = 0; k < ROWS; k++)
      for (int c = 0; c < COLS; c++)
        if (positive)
          s[k][c] = cnn_pkg::weight_t'(($random(seed) & 32'h7f) | 32'h1);  // 1 to 127
        else
          s[k][c] = cnn_pkg::weight_t'($random(seed));
  endtask

  task automatic make_frame(input bit negative);
    for (int t = 0; t < FRAME_LEN; t++)
      for (int r = 0; r < ROWS; r++)
        if (negative)
          frame[t][r] = cnn_pkg::data_t'($random(seed) | 32'h80);  // -128 to -1
        else
          frame[t][r] = cnn_pkg::data_t'($random(seed));
  endtask

  task automatic load_weights(input wmat_t s);
    for (int k = 0; k < ROWS; k++)
    begin
      weight_load_i = 1'b1;
      for (int c = 0; c < COLS; c++)
        weight_i[c] = s[k][c];
      next_cycle();
    end
    weight_load_i = 1'b0;
    weight_i      = '0;
    for (int r = 0; r < ROWS; r++)
      for (int c = 0; c < COLS; c++)
        w_rows[r][c] = s[ROWS-1-r][c];  // first word ends in the bottom row
  endtask

  task automatic run_frame(input int nf, input bit spurious);
    psum_list_t res;
    int         runs_before;
    for (int c = 0; c < nf; c++)
    begin
      res = pool_ref(w_rows, frame, c);
      foreach (res[i])
        exp_q[c].push_back(res[i]);
    end
    runs_before  = finish_cnt;
    start_i      = 1'b1;
    num_filter_i = NF_W'(nf);
    next_cycle();  // edge 0 takes the start
    check("w_ps_o", w_ps_o, 0);  // streaming
    for (int t = 0; t < FRAME_LEN; t++)
    begin
      for (int r = 0; r < ROWS; r++)
        act_i[r] = frame[t][r];
      start_i = spurious && (t == FRAME_LEN / 2);  // must be ignored mid-stream
      next_cycle();
    end
    act_i   = '0;
    start_i = 1'b0;
    while (finish_cnt == runs_before)
      next_cycle();
    next_cycle();  // a longer pulse would count again here
    check("conv_finish_o pulses", finish_cnt, runs_before + 1);
    check("w_ps_o", w_ps_o, 1);
    for (int c = 0; c < COLS; c++)
    begin
      check($sformatf("pool_valid_o[%0d] count", c), valid_cnt[c],
            (c < nf) ? FRAME_LEN / POOL_LEN : 0);
      check($sformatf("pending results col %0d", c), exp_q[c].size(), 0);
      valid_cnt[c] = 0;
    end
  endtask

  // compare on the falling edge, outputs are settled there
  always @(negedge clk)
  begin
    cnn_pkg::psum_t exp_v;
    for (int c = 0; c < COLS; c++)
    begin
      if (pool_valid_o[c])
      begin
        if (exp_q[c].size() == 0)
          abort_run($sformatf("column %0d gave a pooled result that was not expected", c));
        else
        begin
          exp_v = exp_q[c].pop_front();
          check($sformatf("pool_data_o[%0d]", c), pool_data_o[c], exp_v);
          valid_cnt[c]++;
        end
      end
    end
    if (conv_finish_o)
      finish_cnt++;
  end

  initial
  begin
    cycle_cnt = 0;
    forever
    begin
      @(posedge clk);
      cycle_cnt++;
      if (cycle_cnt >= TIMEOUT_CYCLES)
        abort_run($sformatf("run did not complete within %0d cycles", TIMEOUT_CYCLES));
    end
  end

  initial
  begin
    seed          = 32'hd2cf_ea15;
    finish_cnt    = 0;
    nrst          = 1'b0;
    weight_load_i = 1'b0;
    weight_i      = '0;
    start_i       = 1'b0;
    act_i         = '0;
    num_filter_i  = '0;
    for (int c = 0; c < COLS; c++)
      valid_cnt[c] = 0;
    for (int r = 0; r < ROWS; r++)
      for (int c = 0; c < COLS; c++)
        w_rows[r][c] = '0;  // grid weights clear after reset
    repeat (RESET_CYCLES) @(posedge clk);
    #1 nrst = 1'b1;

    check("w_ps_o", w_ps_o, 1);
    check("conv_finish_o", conv_finish_o, 0);
    check("pool_valid_o", pool_valid_o, 0);

    make_frame(1'b0);  // no weights loaded yet
    run_frame(COLS, 1'b0);

    make_weights(1'b0, strobes);
    load_weights(strobes);
    make_frame(1'b0);
    run_frame(COLS, 1'b0);

    make_weights(1'b1, strobes);  // all products negative
    load_weights(strobes);
    make_frame(1'b1);
    run_frame(COLS, 1'b0);

    make_weights(1'b0, strobes);
    load_weights(strobes);
    make_frame(1'b0);
    run_frame(2, 1'b1);

    repeat (4) next_cycle();
    check("conv_finish_o total", finish_cnt, NUM_RUNS);
    for (int c = 0; c < COLS; c++)
      check($sformatf("pending results col %0d", c), exp_q[c].size(), 0);

    $display("TESTS PASSED");
    $finish;
  end

endmodule

// ==== conv_top.sv ====
`timescale 1ns/1ps

module conv_top #(
  parameter int ROWS      = 4,
  parameter int COLS      = 4,
  parameter int FRAME_LEN = 16,
  parameter int POOL_LEN  = 4
) (
  input  logic                         clk,
  input  logic                         nrst,
  input  logic                         weight_load_i,
  input  cnn_pkg::weight_t [COLS-1:0]  weight_i,
  input  logic                         start_i,
  input  cnn_pkg::data_t   [ROWS-1:0]  act_i,
  input  logic [$clog2(COLS+1)-1:0]    num_filter_i,
  output logic             [COLS-1:0]  pool_valid_o,
  output cnn_pkg::psum_t   [COLS-1:0]  pool_data_o,
  output logic                         conv_finish_o,
  output logic                         w_ps_o
);

  logic                       w_ps;
  logic [ROWS-1:0]            input_en;
  logic [COLS-1:0]            out_en;  // one enable per pooling unit
  cnn_pkg::psum_t [COLS-1:0]  col_psum;

  conv_ctrl #(
    .ROWS      (ROWS),
    .COLS      (COLS),
    .FRAME_LEN (FRAME_LEN)
  ) u_ctrl (
    .clk           (clk),
    .nrst          (nrst),
    .start_i       (start_i),
    .num_filter_i  (num_filter_i),
    .w_ps_o        (w_ps),
    .input_en_o    (input_en),
    .out_en_o      (out_en),
    .conv_finish_o (conv_finish_o)
  );

  systolic_array #(
    .ROWS (ROWS),
    .COLS (COLS)
  ) u_array (
    .clk           (clk),
    .nrst          (nrst),
    .w_ps_i        (w_ps),
    .weight_load_i (weight_load_i),
    .weight_i      (weight_i),
    .act_i         (act_i),
    .input_en_i    (input_en),
    .col_psum_o    (col_psum)
  );

  for (genvar c = 0; c < COLS; c++)
  begin : g_pool
    pooling_unit #(
      .POOL_LEN (POOL_LEN)
    ) u_pool (
      .clk          (clk),
      .nrst         (nrst),
      .en_i         (out_en[c]),
      .psum_i       (col_psum[c]),
      .pool_valid_o (pool_valid_o[c]),
      .pool_o       (pool_data_o[c])
    );
  end

  assign w_ps_o = w_ps;

endmodule

// ==== pooling_unit.sv ====
`timescale 1ns/1ps

module pooling_unit #(
  parameter int POOL_LEN = 4
) (
  input  logic           clk,
  input  logic           nrst,
  input  logic           en_i,
  input  cnn_pkg::psum_t psum_i,
  output logic           pool_valid_o,
  output cnn_pkg::psum_t pool_o
);

  localparam int CNT_W = (POOL_LEN > 1) ? $clog2(POOL_LEN) : 1;

  logic [CNT_W-1:0] grp_cnt_q;
  cnn_pkg::psum_t   max_q;
  cnn_pkg::psum_t   max_next;

  // first result of a group starts afresh
  assign max_next = (grp_cnt_q == '0 || psum_i > max_q) ? psum_i : max_q;

  always_ff @(posedge clk, negedge nrst)
  begin
    if (!nrst)
    begin
      grp_cnt_q    <= '0;
      max_q        <= '0;
      pool_o       <= '0;
      pool_valid_o <= 1'b0;
    end
    else
    begin
      pool_valid_o <= 1'b0;
      if (en_i)
      begin
        if (grp_cnt_q == CNT_W'(POOL_LEN - 1))
        begin
          pool_o       <= max_next;  // group complete
          pool_valid_o <= 1'b1;
          grp_cnt_q    <= '0;
        end
        else
          grp_cnt_q <= grp_cnt_q + 1'b1;
        max_q <= max_next;
      end
    end
  end

endmodule

// ==== conv_ctrl.sv ====
`timescale 1ns/1ps

module conv_ctrl #(
  parameter int ROWS      = 4,
  parameter int COLS      = 4,
  parameter int FRAME_LEN = 16
) (
  input  logic                       clk,
  input  logic                       nrst,
  input  logic                       start_i,
  input  logic [$clog2(COLS+1)-1:0]  num_filter_i,
  output logic                       w_ps_o,
  output logic [ROWS-1:0]            input_en_o,
  output logic [COLS-1:0]            out_en_o,
  output logic                       conv_finish_o
);

  localparam int NF_W       = $clog2(COLS + 1);
  localparam int STREAM_END = FRAME_LEN + ROWS - 2;     // last cycle of the last row window
  localparam int RUN_END    = FRAME_LEN + ROWS + COLS;  // finish goes out on the next edge
  localparam int CNT_W      = $clog2(RUN_END + 1);

  cnn_pkg::ctrl_state_t state_q, state_d;
  logic [CNT_W-1:0]     cnt_q, cnt_d;
  logic [NF_W-1:0]      nf_q, nf_d;
  logic                 finish_q, finish_d;

  always_ff @(posedge clk, negedge nrst)
  begin
    if (!nrst)
    begin
      state_q  <= cnn_pkg::LOADING_WEIGHT;
      cnt_q    <= '0;
      nf_q     <= '0;
      finish_q <= 1'b0;
    end
    else
    begin
      state_q  <= state_d;
      cnt_q    <= cnt_d;
      nf_q     <= nf_d;
      finish_q <= finish_d;
    end
  end

  always_comb
  begin
    state_d  = state_q;
    cnt_d    = cnt_q;
    nf_d     = nf_q;
    finish_d = 1'b0;

    case (state_q)
      cnn_pkg::LOADING_WEIGHT:
      begin
        if (start_i)
        begin
          state_d = cnn_pkg::LOADING_PS;
          cnt_d   = '0;
          nf_d    = num_filter_i;  // filter count fixed for the run
        end
      end
      cnn_pkg::LOADING_PS:
      begin
        cnt_d = cnt_q + 1'b1;
        if (cnt_q == CNT_W'(STREAM_END))
          state_d = cnn_pkg::DRAINING;  // all rows have taken their frame
      end
      cnn_pkg::DRAINING:
      begin
        if (cnt_q == CNT_W'(RUN_END))
        begin
          state_d  = cnn_pkg::LOADING_WEIGHT;
          cnt_d    = '0;
          finish_d = 1'b1;
        end
        else
          cnt_d = cnt_q + 1'b1;
      end
      default:
        state_d = cnn_pkg::LOADING_WEIGHT;
    endcase
  end

  // per-index windows of FRAME_LEN cycles, shifted by one per row or column
  always_comb
  begin
    input_en_o = '0;
    out_en_o   = '0;
    if (state_q != cnn_pkg::LOADING_WEIGHT)
    begin
      for (int r = 0; r < ROWS; r++)
        input_en_o[r] = (int'(cnt_q) >= r) && (int'(cnt_q) < r + FRAME_LEN);
      for (int c = 0; c < COLS; c++)
        out_en_o[c] = (c < int'(nf_q)) &&
                      (int'(cnt_q) >= ROWS + c) &&
                      (int'(cnt_q) < ROWS + c + FRAME_LEN);  // masked columns stay low
    end
  end

  assign w_ps_o        = (state_q == cnn_pkg::LOADING_WEIGHT);
  assign conv_finish_o = finish_q;

endmodule

// ==== systolic_array.sv ====
`timescale 1ns/1ps

module systolic_array #(
  parameter int ROWS = 4,
  parameter int COLS = 4
) (
  input  logic                          clk,
  input  logic                          nrst,
  input  logic                          w_ps_i,
  input  logic                          weight_load_i,
  input  cnn_pkg::weight_t [COLS-1:0]   weight_i,
  input  cnn_pkg::data_t   [ROWS-1:0]   act_i,
  input  logic             [ROWS-1:0]   input_en_i,
  output cnn_pkg::psum_t   [COLS-1:0]   col_psum_o
);

  logic           weight_shift;
  cnn_pkg::data_t act_row [ROWS];  // skewed and gated row inputs

  // grid wires, indexed by the PE that drives them
  cnn_pkg::weight_t weight_v [ROWS][COLS];
  cnn_pkg::data_t   act_v    [ROWS][COLS];
  cnn_pkg::psum_t   psum_v   [ROWS][COLS];

  assign weight_shift = weight_load_i & w_ps_i;

  // triangular skew, row r is delayed by r cycles
  for (genvar r = 0; r < ROWS; r++)
  begin : g_skew
    if (r == 0)
    begin : g_direct
      assign act_row[r] = input_en_i[r] ? act_i[r] : '0;
    end
    else
    begin : g_delay
      cnn_pkg::data_t dly_q [r];

      always_ff @(posedge clk)
      begin
        dly_q[0] <= act_i[r];
        for (int k = 1; k < r; k++)
          dly_q[k] <= dly_q[k-1];
      end

      assign act_row[r] = input_en_i[r] ? dly_q[r-1] : '0;  // leftovers stay out
    end
  end

  for (genvar r = 0; r < ROWS; r++)
  begin : g_row
    for (genvar c = 0; c < COLS; c++)
    begin : g_col
      cnn_pkg::weight_t w_in;
      cnn_pkg::data_t   a_in;
      cnn_pkg::psum_t   p_in;

      if (r == 0)
      begin : g_top
        assign w_in = weight_i[c];
        assign p_in = '0;
      end
      else
      begin : g_inner
        assign w_in = weight_v[r-1][c];
        assign p_in = psum_v[r-1][c];
      end

      if (c == 0)
      begin : g_left
        assign a_in = act_row[r];
      end
      else
      begin : g_right
        assign a_in = act_v[r][c-1];
      end

      pe u_pe (
        .clk            (clk),
        .nrst           (nrst),
        .w_ps_i         (w_ps_i),
        .weight_shift_i (weight_shift),
        .weight_i       (w_in),
        .act_i          (a_in),
        .psum_i         (p_in),
        .weight_o       (weight_v[r][c]),
        .act_o          (act_v[r][c]),
        .psum_o         (psum_v[r][c])
      );
    end
  end

  for (genvar c = 0; c < COLS; c++)
  begin : g_out
    assign col_psum_o[c] = psum_v[ROWS-1][c];  // bottom of each column
  end

endmodule

// ==== pe.sv ====
`timescale 1ns/1ps

module pe (
  input  logic            clk,
  input  logic            nrst,
  input  logic            w_ps_i,
  input  logic            weight_shift_i,
  input  cnn_pkg::weight_t weight_i,
  input  cnn_pkg::data_t  act_i,
  input  cnn_pkg::psum_t  psum_i,
  output cnn_pkg::weight_t weight_o,
  output cnn_pkg::data_t  act_o,
  output cnn_pkg::psum_t  psum_o
);

  cnn_pkg::weight_t weight_q;
  cnn_pkg::data_t   act_q;
  cnn_pkg::psum_t   psum_q;

  always_ff @(posedge clk, negedge nrst)
  begin
    if (!nrst)
      weight_q <= '0;
    else if (weight_shift_i)
      weight_q <= weight_i;  // old value moves on to the row below
  end

  // pipeline is flushed while weights load
  always_ff @(posedge clk)
  begin
    if (w_ps_i)
    begin
      act_q  <= '0;
      psum_q <= '0;
    end
    else
    begin
      act_q  <= act_i;  // forward to the right
      psum_q <= psum_i + cnn_pkg::psum_t'(weight_q) * cnn_pkg::psum_t'(act_i);
    end
  end

  assign weight_o = weight_q;
  assign act_o    = act_q;
  assign psum_o   = psum_q;

endmodule

// ==== cnn_pkg.sv ====
package cnn_pkg;

  // datapath widths
  localparam int DATA_W   = 8;
  localparam int WEIGHT_W = 8;
  localparam int PSUM_W   = 20;  // 16 rows of 8x8 products without overflow

  typedef logic signed [DATA_W-1:0]   data_t;    // activation value
  typedef logic signed [WEIGHT_W-1:0] weight_t;  // stationary weight
  typedef logic signed [PSUM_W-1:0]   psum_t;    // partial sum down a column

  // controller states
  typedef enum logic [1:0] {
    LOADING_WEIGHT = 2'b01,  // weight shift allowed
    LOADING_PS     = 2'b11,  // streaming the frame
    DRAINING       = 2'b10   // waiting for the last column
  } ctrl_state_t;

endpackage
